// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_system    = 7'b1110011;

  // integer op funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [11:0] f12_ebreak = 12'h001;
  localparam logic [31:0] nop_word   = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_instr_t;

endpackage

// File: hw/core_ctrl_pkg.sv
package core_ctrl_pkg;

  // alu operation select
  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_sll    = 4'd2;
  localparam logic [3:0] alu_slt    = 4'd3;
  localparam logic [3:0] alu_sltu   = 4'd4;
  localparam logic [3:0] alu_xor    = 4'd5;
  localparam logic [3:0] alu_srl    = 4'd6;
  localparam logic [3:0] alu_sra    = 4'd7;
  localparam logic [3:0] alu_or     = 4'd8;
  localparam logic [3:0] alu_and    = 4'd9;
  localparam logic [3:0] alu_pass_b = 4'd10; // lui

  // immediate format select
  localparam logic [2:0] imm_i = 3'd0;
  localparam logic [2:0] imm_s = 3'd1;
  localparam logic [2:0] imm_b = 3'd2;
  localparam logic [2:0] imm_u = 3'd3;
  localparam logic [2:0] imm_j = 3'd4;

  // write-back source
  localparam logic [1:0] wb_sel_alu  = 2'd0;
  localparam logic [1:0] wb_sel_link = 2'd1;

endpackage

// File: hw/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  rv_isa_pkg::rv_instr_t instr,
  input  logic [2:0]            imm_sel,
  output logic [63:0]           imm
);

  always_comb begin
    case (imm_sel)
      core_ctrl_pkg::imm_i:
        imm = {{52{instr.i.imm11_0[11]}}, instr.i.imm11_0};
      core_ctrl_pkg::imm_s:
        imm = {{52{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
      core_ctrl_pkg::imm_b:
        imm = {{51{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
               instr.b.imm10_5, instr.b.imm4_1, 1'b0};
      core_ctrl_pkg::imm_u:
        imm = {{32{instr.u.imm31_12[19]}}, instr.u.imm31_12, 12'd0};
      core_ctrl_pkg::imm_j:
        imm = {{43{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
               instr.j.imm11, instr.j.imm10_1, 1'b0};
      default:
        imm = 64'd0;
    endcase
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        rstn,
  input  logic [4:0]  rs1_idx,
  input  logic [4:0]  rs2_idx,
  output logic [63:0] rs1_data,
  output logic [63:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  rd_idx,
  input  logic [63:0] rd_data
);

  logic [63:0] regs [0:31];

  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int k = 0; k < 32; k++)
        regs[k] <= 64'd0;
    end else if (we && rd_idx != 5'd0) begin // x0 writes dropped
      regs[rd_idx] <= rd_data;
    end
  end

  // x0 stays zero across any earlier write to it
  assert property (@(posedge clk) disable iff (!rstn)
    (rs1_idx == 5'd0) |-> (rs1_data == 64'd0));

  assert property (@(posedge clk) disable iff (!rstn)
    (rs2_idx == 5'd0) |-> (rs2_data == 64'd0));

endmodule

// File: hw/int_alu.sv
`timescale 1ns/1ps

module int_alu (
  input  logic [63:0] a,
  input  logic [63:0] b,
  input  logic [3:0]  alu_op,
  input  logic        alu_word,
  input  logic        br_en,
  input  logic [2:0]  br_op,
  output logic [63:0] result,
  output logic        br_taken
);

  logic [5:0]  shamt;
  logic [63:0] sh_src;
  logic [63:0] full;
  logic        cmp;

  assign shamt = alu_word ? {1'b0, b[4:0]} : b[5:0];

  // word shifts see only the low half of a
  always_comb begin
    if (!alu_word)
      sh_src = a;
    else if (alu_op == core_ctrl_pkg::alu_sra)
      sh_src = {{32{a[31]}}, a[31:0]};
    else
      sh_src = {32'd0, a[31:0]};
  end

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::alu_add:    full = a + b;
      core_ctrl_pkg::alu_sub:    full = a - b;
      core_ctrl_pkg::alu_sll:    full = a << shamt;
      core_ctrl_pkg::alu_slt:    full = {63'd0, $signed(a) < $signed(b)};
      core_ctrl_pkg::alu_sltu:   full = {63'd0, a < b};
      core_ctrl_pkg::alu_xor:    full = a ^ b;
      core_ctrl_pkg::alu_srl:    full = sh_src >> shamt;
      core_ctrl_pkg::alu_sra:    full = $signed(sh_src) >>> shamt;
      core_ctrl_pkg::alu_or:     full = a | b;
      core_ctrl_pkg::alu_and:    full = a & b;
      core_ctrl_pkg::alu_pass_b: full = b;
      default:                   full = 64'd0;
    endcase
  end

  assign result = alu_word ? {{32{full[31]}}, full[31:0]} : full;

  always_comb begin
    case (br_op)
      rv_isa_pkg::f3_beq:  cmp = (a == b);
      rv_isa_pkg::f3_bne:  cmp = (a != b);
      rv_isa_pkg::f3_blt:  cmp = ($signed(a) < $signed(b));
      rv_isa_pkg::f3_bge:  cmp = ($signed(a) >= $signed(b));
      rv_isa_pkg::f3_bltu: cmp = (a < b);
      rv_isa_pkg::f3_bgeu: cmp = (a >= b);
      default:             cmp = 1'b0;
    endcase
  end

  assign br_taken = br_en && cmp;

endmodule

// File: hw/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter logic [63:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        instr_en,
  input  logic [63:0] imm,
  input  logic [63:0] rs1_data,
  input  logic        br_taken,
  input  logic        jal_en,
  input  logic        jalr_en,
  output logic [63:0] pc,
  output logic [63:0] link,
  output logic [63:0] dnxt_pc
);

  logic [63:0] jalr_tgt;

  assign link     = pc + 64'd4;
  assign jalr_tgt = rs1_data + imm;

  always_comb begin
    if (!instr_en)
      dnxt_pc = pc; // hold while waiting for read data
    else if (jalr_en)
      dnxt_pc = {jalr_tgt[63:1], 1'b0};
    else if (br_taken || jal_en)
      dnxt_pc = pc + imm;
    else
      dnxt_pc = link;
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      pc <= RESET_PC;
    else if (instr_en)
      pc <= dnxt_pc;
  end

endmodule

// File: hw/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  output logic                  ifu_arvalid,
  input  logic                  ifu_arready,
  output logic [63:0]           ifu_araddr,
  input  logic                  ifu_rvalid,
  input  logic [31:0]           ifu_rdata,
  input  logic [1:0]            ifu_rresp,
  input  logic [63:0]           dnxt_pc,
  output rv_isa_pkg::rv_instr_t instr,
  output logic                  instr_en,
  output logic [4:0]            rs1_idx,
  output logic [4:0]            rs2_idx,
  output logic [4:0]            rd_idx,
  output logic [2:0]            imm_sel,
  output logic [3:0]            alu_op,
  output logic                  alu_word,
  output logic                  alu_src_pc,
  output logic                  alu_src_imm,
  output logic                  br_en,
  output logic [2:0]            br_op,
  output logic                  jal_en,
  output logic                  jalr_en,
  output logic                  wb_en,
  output logic [1:0]            wb_sel,
  output logic                  halted
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_fetch = 2'd1;
  localparam logic [1:0] st_exec  = 2'd2;
  localparam logic [1:0] st_halt  = 2'd3;

  localparam logic [1:0] resp_okay = 2'b00;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       is_ebreak;

  function automatic logic [3:0] alu_fn(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
    case (f3)
      rv_isa_pkg::f3_add_sub: alu_fn = (alt && reg_form) ? core_ctrl_pkg::alu_sub
                                                         : core_ctrl_pkg::alu_add;
      rv_isa_pkg::f3_sll:     alu_fn = core_ctrl_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     alu_fn = core_ctrl_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    alu_fn = core_ctrl_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     alu_fn = core_ctrl_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: alu_fn = alt ? core_ctrl_pkg::alu_sra : core_ctrl_pkg::alu_srl;
      rv_isa_pkg::f3_or:      alu_fn = core_ctrl_pkg::alu_or;
      default:                alu_fn = core_ctrl_pkg::alu_and;
    endcase
  endfunction

  assign instr_en   = ifu_rvalid && (state_q == st_exec); // retire cycle
  assign ifu_araddr = dnxt_pc;
  assign halted     = (state_q == st_halt);

  // error responses and idle cycles decode as nop
  assign instr = (instr_en && ifu_rresp == resp_okay) ? ifu_rdata : rv_isa_pkg::nop_word;

  assign is_ebreak = (instr.i.opcode == rv_isa_pkg::opc_system) &&
                     (instr.i.imm11_0 == rv_isa_pkg::f12_ebreak) &&
                     (instr.i.funct3 == 3'b000) && (instr.i.rs1 == 5'd0) &&
                     (instr.i.rd == 5'd0);

  always_ff @(posedge clk) begin
    if (!rstn)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  always_comb begin
    state_d     = state_q;
    ifu_arvalid = 1'b0;
    case (state_q)
      st_idle: state_d = st_fetch;
      st_fetch: begin
        ifu_arvalid = 1'b1;
        if (ifu_arready)
          state_d = st_exec;
      end
      st_exec: begin
        if (instr_en) begin
          if (is_ebreak) begin
            state_d = st_halt;
          end else begin
            ifu_arvalid = 1'b1; // next fetch in the retire cycle
            state_d     = ifu_arready ? st_exec : st_fetch;
          end
        end
      end
      default: state_d = st_halt;
    endcase
  end

  always_comb begin
    rs1_idx     = instr.r.rs1;
    rs2_idx     = instr.r.rs2;
    rd_idx      = instr.r.rd;
    br_op       = instr.r.funct3;
    imm_sel     = core_ctrl_pkg::imm_i;
    alu_op      = core_ctrl_pkg::alu_add;
    alu_word    = 1'b0;
    alu_src_pc  = 1'b0;
    alu_src_imm = 1'b0;
    br_en       = 1'b0;
    jal_en      = 1'b0;
    jalr_en     = 1'b0;
    wb_en       = 1'b0;
    wb_sel      = core_ctrl_pkg::wb_sel_alu;
    case (instr.r.opcode)
      rv_isa_pkg::opc_lui: begin
        imm_sel     = core_ctrl_pkg::imm_u;
        alu_op      = core_ctrl_pkg::alu_pass_b;
        alu_src_imm = 1'b1;
        wb_en       = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        imm_sel     = core_ctrl_pkg::imm_u;
        alu_src_pc  = 1'b1;
        alu_src_imm = 1'b1;
        wb_en       = 1'b1;
      end
      rv_isa_pkg::opc_jal: begin
        imm_sel = core_ctrl_pkg::imm_j;
        jal_en  = 1'b1;
        wb_en   = 1'b1;
        wb_sel  = core_ctrl_pkg::wb_sel_link;
      end
      rv_isa_pkg::opc_jalr: begin
        jalr_en = 1'b1;
        wb_en   = 1'b1;
        wb_sel  = core_ctrl_pkg::wb_sel_link;
      end
      rv_isa_pkg::opc_branch: begin
        imm_sel = core_ctrl_pkg::imm_b;
        br_en   = 1'b1;
      end
      rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_op_imm_32: begin
        alu_op      = alu_fn(instr.i.funct3, instr.i.imm11_0[10], 1'b0); // bit 30 picks sra
        alu_word    = (instr.i.opcode == rv_isa_pkg::opc_op_imm_32);
        alu_src_imm = 1'b1;
        wb_en       = 1'b1;
      end
      rv_isa_pkg::opc_op, rv_isa_pkg::opc_op_32: begin
        alu_op   = alu_fn(instr.r.funct3, instr.r.funct7[5], 1'b1);
        alu_word = (instr.r.opcode == rv_isa_pkg::opc_op_32);
        wb_en    = !instr.r.funct7[0]; // mul/div words retire as nop
      end
      default: ; // loads, stores, system
    endcase
  end

  // address must not move or drop before it is taken
  assert property (@(posedge clk) disable iff (!rstn)
    ifu_arvalid && !ifu_arready |=> ifu_arvalid && $stable(ifu_araddr));

  assert property (@(posedge clk) disable iff (!rstn)
    halted |=> halted && !ifu_arvalid);

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter logic [63:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic        clk,
  input  logic        rstn,
  output logic        ifu_arvalid,
  input  logic        ifu_arready,
  output logic [63:0] ifu_araddr,
  input  logic        ifu_rvalid,
  input  logic [31:0] ifu_rdata,
  input  logic [1:0]  ifu_rresp,
  output logic        wb_valid,
  output logic [4:0]  wb_rd,
  output logic [63:0] wb_data,
  output logic        halted
);

  rv_isa_pkg::rv_instr_t instr;

  logic        instr_en;
  logic [4:0]  rs1_idx;
  logic [4:0]  rs2_idx;
  logic [4:0]  rd_idx;
  logic [2:0]  imm_sel;
  logic [3:0]  alu_op;
  logic        alu_word;
  logic        alu_src_pc;
  logic        alu_src_imm;
  logic        br_en;
  logic [2:0]  br_op;
  logic        br_taken;
  logic        jal_en;
  logic        jalr_en;
  logic        wb_en;
  logic [1:0]  wb_sel;
  logic [63:0] imm;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] alu_a;
  logic [63:0] alu_b;
  logic [63:0] alu_result;
  logic [63:0] pc;
  logic [63:0] link;
  logic [63:0] dnxt_pc;
  logic        rf_we;

  assign alu_a    = alu_src_pc ? pc : rs1_data;
  assign alu_b    = alu_src_imm ? imm : rs2_data;
  assign wb_data  = (wb_sel == core_ctrl_pkg::wb_sel_link) ? link : alu_result;
  assign rf_we    = wb_en && instr_en;
  assign wb_valid = rf_we && (rd_idx != 5'd0);
  assign wb_rd    = rd_idx;

  core_ctrl u_ctrl (
    .clk(clk), .rstn(rstn),
    .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready), .ifu_araddr(ifu_araddr),
    .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp),
    .dnxt_pc(dnxt_pc), .instr(instr), .instr_en(instr_en),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx), .imm_sel(imm_sel),
    .alu_op(alu_op), .alu_word(alu_word), .alu_src_pc(alu_src_pc),
    .alu_src_imm(alu_src_imm), .br_en(br_en), .br_op(br_op),
    .jal_en(jal_en), .jalr_en(jalr_en), .wb_en(wb_en), .wb_sel(wb_sel),
    .halted(halted)
  );

  imm_gen u_imm (.instr(instr), .imm_sel(imm_sel), .imm(imm));

  reg_file u_rf (
    .clk(clk), .rstn(rstn),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(rf_we), .rd_idx(rd_idx), .rd_data(wb_data)
  );

  int_alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .alu_word(alu_word),
    .br_en(br_en), .br_op(br_op), .result(alu_result), .br_taken(br_taken)
  );

  pc_unit #(.RESET_PC(RESET_PC)) u_pc (
    .clk(clk), .rstn(rstn), .instr_en(instr_en), .imm(imm), .rs1_data(rs1_data),
    .br_taken(br_taken), .jal_en(jal_en), .jalr_en(jalr_en),
    .pc(pc), .link(link), .dnxt_pc(dnxt_pc)
  );

endmodule

// File: include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: instruction word, SLVERR response, retired, expected rd (0 = no write-back),
// expected write-back data. row k sits at reset_pc + 4*k
typedef struct packed {
  logic [31:0] word;
  logic        err;
  logic        run;
  logic [4:0]  rd;
  logic [63:0] data;
} prog_row_t;

localparam int prog_len = 46;

prog_row_t prog_tab [prog_len] = '{
  '{32'h00500093, 1'b0, 1'b1, 5'd1,  64'h0000_0000_0000_0005}, // addi x1, x0, 5
  '{32'hffd00113, 1'b0, 1'b1, 5'd2,  64'hffff_ffff_ffff_fffd}, // addi x2, x0, -3
  '{32'h002081b3, 1'b0, 1'b1, 5'd3,  64'h0000_0000_0000_0002}, // add x3, x1, x2
  '{32'h40208233, 1'b0, 1'b1, 5'd4,  64'h0000_0000_0000_0008}, // sub x4, x1, x2
  '{32'h00411293, 1'b0, 1'b1, 5'd5,  64'hffff_ffff_ffff_ffd0}, // slli x5, x2, 4
  '{32'h03c15313, 1'b0, 1'b1, 5'd6,  64'h0000_0000_0000_000f}, // srli x6, x2, 60
  '{32'h40115393, 1'b0, 1'b1, 5'd7,  64'hffff_ffff_ffff_fffe}, // srai x7, x2, 1
  '{32'h00112433, 1'b0, 1'b1, 5'd8,  64'h0000_0000_0000_0001}, // slt x8, x2, x1
  '{32'h001134b3, 1'b0, 1'b1, 5'd9,  64'h0000_0000_0000_0000}, // sltu x9, x2, x1
  '{32'h0ff0c513, 1'b0, 1'b1, 5'd10, 64'h0000_0000_0000_00fa}, // xori x10, x1, 0xff
  '{32'h0020e5b3, 1'b0, 1'b1, 5'd11, 64'hffff_ffff_ffff_fffd}, // or x11, x1, x2
  '{32'h0020f633, 1'b0, 1'b1, 5'd12, 64'h0000_0000_0000_0005}, // and x12, x1, x2
  '{32'h800006b7, 1'b0, 1'b1, 5'd13, 64'hffff_ffff_8000_0000}, // lui x13, 0x80000
  '{32'h00001717, 1'b0, 1'b1, 5'd14, 64'h0000_0000_8000_1034}, // auipc x14, 0x1
  '{32'hfff6879b, 1'b0, 1'b1, 5'd15, 64'h0000_0000_7fff_ffff}, // addiw x15, x13, -1
  '{32'h00d6883b, 1'b0, 1'b1, 5'd16, 64'h0000_0000_0000_0000}, // addw x16, x13, x13
  '{32'h004118bb, 1'b0, 1'b1, 5'd17, 64'hffff_ffff_ffff_fd00}, // sllw x17, x2, x4
  '{32'h4016d93b, 1'b0, 1'b1, 5'd18, 64'hffff_ffff_fc00_0000}, // sraw x18, x13, x1
  '{32'h00708013, 1'b0, 1'b1, 5'd0,  64'h0}, // addi x0, x1, 7
  '{32'h001009b3, 1'b0, 1'b1, 5'd19, 64'h0000_0000_0000_0005}, // add x19, x0, x1
  '{32'h06300a13, 1'b1, 1'b1, 5'd0,  64'h0}, // addi x20, x0, 99 answered with SLVERR
  '{32'h0000ac03, 1'b0, 1'b1, 5'd0,  64'h0}, // lw x24, 0(x1), no data port
  '{32'h00208463, 1'b0, 1'b1, 5'd0,  64'h0}, // beq x1, x2 not taken
  '{32'h01308463, 1'b0, 1'b1, 5'd0,  64'h0}, // beq x1, x19 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0}, // skipped
  '{32'h01309463, 1'b0, 1'b1, 5'd0,  64'h0}, // bne x1, x19 not taken
  '{32'h00209463, 1'b0, 1'b1, 5'd0,  64'h0}, // bne x1, x2 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h0020c463, 1'b0, 1'b1, 5'd0,  64'h0}, // blt x1, x2 not taken
  '{32'h00114463, 1'b0, 1'b1, 5'd0,  64'h0}, // blt x2, x1 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h00115463, 1'b0, 1'b1, 5'd0,  64'h0}, // bge x2, x1 not taken
  '{32'h0020d463, 1'b0, 1'b1, 5'd0,  64'h0}, // bge x1, x2 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h00116463, 1'b0, 1'b1, 5'd0,  64'h0}, // bltu x2, x1 not taken
  '{32'h0020e463, 1'b0, 1'b1, 5'd0,  64'h0}, // bltu x1, x2 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h0020f463, 1'b0, 1'b1, 5'd0,  64'h0}, // bgeu x1, x2 not taken
  '{32'h00117463, 1'b0, 1'b1, 5'd0,  64'h0}, // bgeu x2, x1 taken
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h00800aef, 1'b0, 1'b1, 5'd21, 64'h0000_0000_8000_00a4}, // jal x21, +8
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h00000b97, 1'b0, 1'b1, 5'd23, 64'h0000_0000_8000_00a8}, // auipc x23, 0
  '{32'h00db8b67, 1'b0, 1'b1, 5'd22, 64'h0000_0000_8000_00b0}, // jalr x22, 13(x23)
  '{32'hfff00c93, 1'b0, 1'b0, 5'd0,  64'h0},
  '{32'h00100073, 1'b0, 1'b1, 5'd0,  64'h0}  // ebreak
};

`endif

// File: sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;

  `include "tb_program.svh"

  localparam int max_cycles = prog_len * 12;

  logic        clk;
  logic        rstn;
  logic        ifu_arvalid;
  logic        ifu_arready;
  logic [63:0] ifu_araddr;
  logic        ifu_rvalid;
  logic [31:0] ifu_rdata;
  logic [1:0]  ifu_rresp;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  logic        halted;

  logic [31:0] lfsr;
  int          next_row;   // next row that should be fetched
  int          exec_row;   // row of the outstanding read
  int          retired;
  int          n_run;
  bit          pending;
  logic [3:0]  lat_cnt;
  bit          stalled;
  logic [63:0] stall_addr;

  core_top #(.RESET_PC(reset_pc)) DUT (
    .clk(clk), .rstn(rstn),
    .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready), .ifu_araddr(ifu_araddr),
    .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [3:0] v);
    v = 4'd0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[2:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("Timeout: the core did not halt within %0d cycles", max_cycles);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    logic [3:0] r;
    prog_row_t  row;
    rstn        = 1'b0;
    ifu_arready = 1'b0;
    ifu_rvalid  = 1'b0;
    ifu_rdata   = 32'd0;
    ifu_rresp   = 2'b00;
    lfsr        = 32'h38353f15;
    next_row    = 0;
    exec_row    = 0;
    retired     = 0;
    n_run       = 0;
    pending     = 1'b0;
    lat_cnt     = 4'd0;
    stalled     = 1'b0;
    stall_addr  = 64'd0;
    foreach (prog_tab[k]) begin
      if (prog_tab[k].run)
        n_run++;
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("ifu_arvalid", 64'(ifu_arvalid), 64'd0);
    check_value("wb_valid", 64'(wb_valid), 64'd0);
    check_value("halted", 64'(halted), 64'd0);
    @(posedge clk);
    #2 rstn = 1'b1;

    while (retired < n_run) begin
      @(posedge clk);
      #2;
      rand_bits(1, r);
      ifu_arready = r[0];
      if (pending && lat_cnt == 4'd0) begin
        ifu_rvalid = 1'b1;
        ifu_rdata  = prog_tab[exec_row].word;
        ifu_rresp  = prog_tab[exec_row].err ? 2'b10 : 2'b00;
      end else begin
        ifu_rvalid = 1'b0;
        ifu_rdata  = 32'd0;
        ifu_rresp  = 2'b00;
        if (pending)
          lat_cnt--;
      end

      @(negedge clk);
      if (ifu_rvalid) begin // retire cycle
        row = prog_tab[exec_row];
        check_value("wb_valid", 64'(wb_valid), 64'(row.rd != 5'd0));
        if (row.rd != 5'd0) begin
          check_value("wb_rd", 64'(wb_rd), 64'(row.rd));
          check_value("wb_data", wb_data, row.data);
        end
        pending = 1'b0;
        retired++;
      end else begin
        check_value("wb_valid", 64'(wb_valid), 64'd0);
      end
      if (stalled) begin
        check_value("ifu_arvalid", 64'(ifu_arvalid), 64'd1);
        check_value("ifu_araddr", ifu_araddr, stall_addr);
      end
      if (ifu_arvalid && pending)
        abort_run("A fetch was issued while a read was still outstanding");
      stalled    = ifu_arvalid && !ifu_arready;
      stall_addr = ifu_araddr;
      if (ifu_arvalid && ifu_arready) begin
        while (next_row < prog_len && !prog_tab[next_row].run)
          next_row++;
        if (next_row >= prog_len)
          abort_run("The core fetched past the end of the program");
        check_value("ifu_araddr", ifu_araddr, reset_pc + 64'(next_row * 4));
        exec_row = int'((ifu_araddr - reset_pc) >> 2); // memory indexed by address
        next_row++;
        pending = 1'b1;
        rand_bits(2, r);
        lat_cnt = r; // 1 to 4 cycles
      end
    end

    // after ebreak nothing more may be fetched
    repeat (6) begin
      @(posedge clk);
      #2;
      rand_bits(1, r);
      ifu_arready = r[0];
      ifu_rvalid  = 1'b0;
      @(negedge clk);
      check_value("halted", 64'(halted), 64'd1);
      check_value("ifu_arvalid", 64'(ifu_arvalid), 64'd0);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/int_alu.sv
hw/pc_unit.sv
hw/core_ctrl.sv
hw/core_top.sv
sim/tb_core.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_core
FILELIST  := filelist.f
OBJDIR    := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJDIR)
